// ==== rtl/ldx_consts.svh ====
/*
 * Load execution path constants
 * Queue depth, word and address widths, and the access size codes
 * shared by the store queue, load queue and load formatting logic
 */

`ifndef LDX_CONSTS_SVH
`define LDX_CONSTS_SVH

// Store queue and load queue depth
`define LDX_SIZE_LSQ        8
`define LDX_LSQ_LOG         3

// Data word and byte address
`define LDX_SIZE_DATA       32
`define LDX_SIZE_ADDR       16

// Byte position inside a data word
`define LDX_BYTE_OFFSET     2
`define LDX_BYTES           4

// Access size codes, ordered so that a larger code covers more bytes
`define LDX_SIZE_BYTE       2'd0
`define LDX_SIZE_HALF       2'd1
`define LDX_SIZE_WORD       2'd2

`endif

// ==== rtl/ldxPkg.sv ====
/*
 * Load execution path types
 * Execute requests, load dispatch, store queue pointers and entries,
 * and the violation report
 */

`include "ldx_consts.svh"

package ldxPkg;

	typedef logic [1:0]                ldstSize_t;
	typedef logic [`LDX_LSQ_LOG-1:0]   lsqIdx_t;

	// Load or store leaving address generation
	typedef struct packed {
		logic                          valid;
		lsqIdx_t                       lsqId;
		logic [`LDX_SIZE_ADDR-1:0]     addr;
		ldstSize_t                     size;
		logic                          ldSign;
		logic [`LDX_SIZE_DATA-1:0]     data;
	} memReq_t;

	// Load entering the load queue with its last older store
	typedef struct packed {
		logic                          valid;
		lsqIdx_t                       ldqId;
		lsqIdx_t                       lastSt;
	} dispPkt_t;

	// Pointers owned by the store queue control
	typedef struct packed {
		lsqIdx_t                       head;
		lsqIdx_t                       tail;
		logic [`LDX_LSQ_LOG:0]         count;
	} stqState_t;

	typedef struct packed {
		logic                                          addrValid;
		logic [`LDX_SIZE_ADDR-1:`LDX_BYTE_OFFSET]      wordAddr;
		logic [`LDX_BYTE_OFFSET-1:0]                   offset;
		ldstSize_t                                     size;
		logic [`LDX_SIZE_DATA-1:0]                     data;
	} stqEntry_t;

	typedef struct packed {
		logic                          valid;
		lsqIdx_t                       lsqId;
	} ldxVio_t;

endpackage

// ==== rtl/storeQueue.sv ====
/*
 * Store queue payload
 * Holds address, size and data of each store written at execute,
 * and drives the memory write port from the head entry at commit
 */

`timescale 1ns/1ps
`include "ldx_consts.svh"

module storeQueue (
	input  logic                          clk,
	input  logic                          reset,
	input  ldxPkg::memReq_t               stReq_i,
	input  ldxPkg::stqState_t             stq_i,
	input  logic                          commitSt_i,
	output ldxPkg::stqEntry_t             stqEntries_o [`LDX_SIZE_LSQ],
	output logic [`LDX_SIZE_ADDR-1:0]     stAddr_o,
	output logic [`LDX_SIZE_DATA-1:0]     stData_o,
	output logic [`LDX_BYTES-1:0]         stEn_o
);

	import ldxPkg::*;

	stqEntry_t                      stqMem [`LDX_SIZE_LSQ];
	logic [`LDX_SIZE_LSQ-1:0]       addrValid;
	stqEntry_t                      headEntry;
	logic [`LDX_BYTES-1:0]          sizeMask;

	// Payload written when the store executes
	always_ff @(posedge clk)
	begin
		if (stReq_i.valid)
		begin
			stqMem[stReq_i.lsqId] <= '{
				addrValid: 1'b1,
				wordAddr:  stReq_i.addr[`LDX_SIZE_ADDR-1:`LDX_BYTE_OFFSET],
				offset:    stReq_i.addr[`LDX_BYTE_OFFSET-1:0],
				size:      stReq_i.size,
				data:      stReq_i.data
			};
		end
	end

	// Commit frees the head; an executing store claims its own slot
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			addrValid <= '0;
		end
		else
		begin
			if (commitSt_i)
			begin
				addrValid[stq_i.head] <= 1'b0;
			end
			if (stReq_i.valid)
			begin
				addrValid[stReq_i.lsqId] <= 1'b1;
			end
		end
	end

	always_comb
	begin
		for (int i = 0; i < `LDX_SIZE_LSQ; i++)
		begin
			stqEntries_o[i]           = stqMem[i];
			stqEntries_o[i].addrValid = addrValid[i];
		end
	end

	assign headEntry = stqMem[stq_i.head];

	always_comb
	begin
		case (headEntry.size)
			`LDX_SIZE_BYTE: sizeMask = 4'b0001;
			`LDX_SIZE_HALF: sizeMask = 4'b0011;
			`LDX_SIZE_WORD: sizeMask = 4'b1111;
			default:        sizeMask = 4'b0000;
		endcase
	end

	// Word aligned write, lanes picked by the byte enables
	assign stAddr_o = {headEntry.wordAddr, {`LDX_BYTE_OFFSET{1'b0}}};
	assign stData_o = headEntry.data << {headEntry.offset, 3'b000};
	assign stEn_o   = commitSt_i ? (sizeMask << headEntry.offset) : '0;

	// The committing store must have executed
	commitHasAddr: assert property (@(posedge clk) disable iff (reset)
		commitSt_i |-> addrValid[stq_i.head]);

endmodule

// ==== rtl/loadQueue.sv ====
/*
 * Load queue last-store record
 * Keeps, per load, the index of its last older store and whether
 * that store is still in the store queue
 */

`timescale 1ns/1ps
`include "ldx_consts.svh"

module loadQueue (
	input  logic                          clk,
	input  logic                          reset,
	input  ldxPkg::dispPkt_t              disp_i,
	input  ldxPkg::stqState_t             stq_i,
	input  logic                          commitSt_i,
	input  logic                          commitLd_i,
	input  ldxPkg::lsqIdx_t               commitLdIdx_i,
	input  ldxPkg::lsqIdx_t               ldLsqId_i,
	output ldxPkg::lsqIdx_t               lastSt_o,
	output logic                          lastStValid_o
);

	import ldxPkg::*;

	lsqIdx_t                        lastSt [`LDX_SIZE_LSQ];
	logic [`LDX_SIZE_LSQ-1:0]       lastStValid;
	logic [`LDX_SIZE_LSQ-1:0]       lastStValidNext;
	logic                           stqEmpty;

	// Empty once this cycle's commit has left
	assign stqEmpty = ((stq_i.count - {{`LDX_LSQ_LOG{1'b0}}, commitSt_i}) == '0);

	always_comb
	begin
		lastStValidNext = lastStValid;

		// Loads whose last store leaves the queue see no older store
		if (commitSt_i)
		begin
			for (int i = 0; i < `LDX_SIZE_LSQ; i++)
			begin
				if (lastSt[i] == stq_i.head)
				begin
					lastStValidNext[i] = 1'b0;
				end
			end
		end

		if (disp_i.valid)
		begin
			lastStValidNext[disp_i.ldqId] = !stqEmpty;
		end

		if (commitLd_i)
		begin
			lastStValidNext[commitLdIdx_i] = 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (disp_i.valid)
		begin
			lastSt[disp_i.ldqId] <= disp_i.lastSt;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			lastStValid <= '0;
		end
		else
		begin
			lastStValid <= lastStValidNext;
		end
	end

	assign lastSt_o      = lastSt[ldLsqId_i];
	assign lastStValid_o = lastStValid[ldLsqId_i];

	// Dispatch reuses an entry only after its load has retired
	noDispOnCommit: assert property (@(posedge clk) disable iff (reset)
		!(disp_i.valid && commitLd_i && (disp_i.ldqId == commitLdIdx_i)));

endmodule

// ==== rtl/storeForward.sv ====
/*
 * Load disambiguation
 * Checks a load against the stores older than it and decides between
 * forwarding, reading memory, or flagging a partial overlap
 */

`timescale 1ns/1ps
`include "ldx_consts.svh"

module storeForward (
	input  ldxPkg::memReq_t               ldReq_i,
	input  ldxPkg::stqEntry_t             stqEntries_i [`LDX_SIZE_LSQ],
	input  ldxPkg::stqState_t             stq_i,
	input  ldxPkg::lsqIdx_t               lastSt_i,
	input  logic                          lastStValid_i,
	output logic                          fwdHit_o,
	output logic [`LDX_SIZE_DATA-1:0]     fwdData_o,
	output ldxPkg::ldxVio_t               vio_o
);

	import ldxPkg::*;

	logic                           lastStInQueue;
	logic                           stqWrap;
	logic [`LDX_SIZE_LSQ-1:0]       window;
	logic [`LDX_SIZE_LSQ-1:0]       wordMatch;
	logic [`LDX_SIZE_LSQ-1:0]       offsetMatch;
	logic [`LDX_SIZE_LSQ-1:0]       sizeCover;
	logic [`LDX_SIZE_LSQ-1:0]       candidate;
	logic                           fwdMatch;
	logic                           partialMatch;
	lsqIdx_t                        matchIdx;
	lsqIdx_t                        scanIdx;

	// Head equal to tail is both full and empty, count tells them apart
	assign lastStInQueue = (stq_i.head < stq_i.tail) ?
		((lastSt_i >= stq_i.head) && (lastSt_i < stq_i.tail)) :
		((stq_i.count != '0) && ((lastSt_i < stq_i.tail) || (lastSt_i >= stq_i.head)));

	assign stqWrap = (stq_i.head > lastSt_i);

	always_comb
	begin
		for (int i = 0; i < `LDX_SIZE_LSQ; i++)
		begin
			if (!(lastStValid_i && lastStInQueue))
			begin
				window[i] = 1'b0;
			end
			else if (stqWrap)
			begin
				window[i] = (i <= lastSt_i) || (i >= stq_i.head);
			end
			else
			begin
				window[i] = (i >= stq_i.head) && (i <= lastSt_i);
			end

			wordMatch[i]   = (stqEntries_i[i].wordAddr ==
				ldReq_i.addr[`LDX_SIZE_ADDR-1:`LDX_BYTE_OFFSET]);
			offsetMatch[i] = (stqEntries_i[i].offset == ldReq_i.addr[`LDX_BYTE_OFFSET-1:0]);
			sizeCover[i]   = (stqEntries_i[i].size >= ldReq_i.size);
			candidate[i]   = window[i] && stqEntries_i[i].addrValid && wordMatch[i];
		end
	end

	// Oldest to youngest, so the last hit is the youngest store
	always_comb
	begin
		fwdMatch     = 1'b0;
		partialMatch = 1'b0;
		matchIdx     = '0;
		scanIdx      = '0;

		for (int k = 0; k < `LDX_SIZE_LSQ; k++)
		begin
			scanIdx = stq_i.head + lsqIdx_t'(k);
			if (candidate[scanIdx])
			begin
				fwdMatch     = offsetMatch[scanIdx] && sizeCover[scanIdx];
				partialMatch = !(offsetMatch[scanIdx] && sizeCover[scanIdx]);
				matchIdx     = scanIdx;
			end
		end
	end

	assign fwdHit_o    = ldReq_i.valid && fwdMatch;
	assign fwdData_o   = stqEntries_i[matchIdx].data;
	assign vio_o.valid = ldReq_i.valid && partialMatch;
	assign vio_o.lsqId = ldReq_i.lsqId;

endmodule

// ==== rtl/loadFormat.sv ====
/*
 * Load data formatting
 * Picks forwarded or memory data, aligns the addressed bytes
 * and sign or zero extends them to a full word
 */

`timescale 1ns/1ps
`include "ldx_consts.svh"

module loadFormat (
	input  ldxPkg::memReq_t               ldReq_i,
	input  logic [`LDX_SIZE_DATA-1:0]     memData_i,
	input  logic                          fwdHit_i,
	input  logic [`LDX_SIZE_DATA-1:0]     fwdData_i,
	output logic [`LDX_SIZE_DATA-1:0]     loadData_o,
	output logic                          loadDataValid_o
);

	logic [`LDX_BYTE_OFFSET-1:0]    offset;
	logic [`LDX_SIZE_DATA-1:0]      rawData;
	logic                           aligned;

	assign offset = ldReq_i.addr[`LDX_BYTE_OFFSET-1:0];

	// Forwarded data already sits in the low lanes
	assign rawData = fwdHit_i ? fwdData_i : (memData_i >> {offset, 3'b000});

	always_comb
	begin
		case (ldReq_i.size)
			`LDX_SIZE_BYTE:
				loadData_o = {{(`LDX_SIZE_DATA-8){ldReq_i.ldSign & rawData[7]}}, rawData[7:0]};
			`LDX_SIZE_HALF:
				loadData_o = {{(`LDX_SIZE_DATA-16){ldReq_i.ldSign & rawData[15]}},
					rawData[15:0]};
			default:
				loadData_o = rawData;
		endcase
	end

	assign loadDataValid_o = ldReq_i.valid;

	assign aligned = (ldReq_i.size == `LDX_SIZE_HALF) ? !offset[0] :
		(ldReq_i.size == `LDX_SIZE_WORD) ? (offset == '0) : 1'b1;

	// Address generation never sends a misaligned load
	alignedLoad: assert final (!ldReq_i.valid || aligned);

endmodule

// ==== rtl/ldxPath.sv ====
/*
 * Load execution path
 * Store queue payload, load queue record, disambiguation and
 * load formatting around an external single-cycle memory
 */

`timescale 1ns/1ps
`include "ldx_consts.svh"

module ldxPath (
	input  logic                          clk,
	input  logic                          reset,
	input  ldxPkg::memReq_t               stReq_i,
	input  ldxPkg::memReq_t               ldReq_i,
	input  ldxPkg::dispPkt_t              disp_i,
	input  ldxPkg::stqState_t             stq_i,
	input  logic                          commitSt_i,
	input  logic                          commitLd_i,
	input  ldxPkg::lsqIdx_t               commitLdIdx_i,
	input  logic [`LDX_SIZE_DATA-1:0]     ldData_i,
	output logic [`LDX_SIZE_ADDR-1:0]     ldAddr_o,
	output logic [`LDX_SIZE_ADDR-1:0]     stAddr_o,
	output logic [`LDX_SIZE_DATA-1:0]     stData_o,
	output logic [`LDX_BYTES-1:0]         stEn_o,
	output logic [`LDX_SIZE_DATA-1:0]     loadData_o,
	output logic                          loadDataValid_o,
	output ldxPkg::ldxVio_t               vio_o
);

	import ldxPkg::*;

	stqEntry_t                      stqEntries [`LDX_SIZE_LSQ];
	lsqIdx_t                        lastSt;
	logic                           lastStValid;
	logic                           fwdHit;
	logic [`LDX_SIZE_DATA-1:0]      fwdData;

	// Memory returns the whole word; formatting picks the lanes
	assign ldAddr_o = {ldReq_i.addr[`LDX_SIZE_ADDR-1:`LDX_BYTE_OFFSET], {`LDX_BYTE_OFFSET{1'b0}}};

	storeQueue i_storeQueue (
		.clk              (clk),
		.reset            (reset),
		.stReq_i          (stReq_i),
		.stq_i            (stq_i),
		.commitSt_i       (commitSt_i),
		.stqEntries_o     (stqEntries),
		.stAddr_o         (stAddr_o),
		.stData_o         (stData_o),
		.stEn_o           (stEn_o)
	);

	loadQueue i_loadQueue (
		.clk              (clk),
		.reset            (reset),
		.disp_i           (disp_i),
		.stq_i            (stq_i),
		.commitSt_i       (commitSt_i),
		.commitLd_i       (commitLd_i),
		.commitLdIdx_i    (commitLdIdx_i),
		.ldLsqId_i        (ldReq_i.lsqId),
		.lastSt_o         (lastSt),
		.lastStValid_o    (lastStValid)
	);

	storeForward i_storeForward (
		.ldReq_i          (ldReq_i),
		.stqEntries_i     (stqEntries),
		.stq_i            (stq_i),
		.lastSt_i         (lastSt),
		.lastStValid_i    (lastStValid),
		.fwdHit_o         (fwdHit),
		.fwdData_o        (fwdData),
		.vio_o            (vio_o)
	);

	loadFormat i_loadFormat (
		.ldReq_i          (ldReq_i),
		.memData_i        (ldData_i),
		.fwdHit_i         (fwdHit),
		.fwdData_i        (fwdData),
		.loadData_o       (loadData_o),
		.loadDataValid_o  (loadDataValid_o)
	);

endmodule

// ==== sim/ldxPathTb.sv ====
/*
 * Load execution path testbench
 * Applies a table of dispatches, stores, commits and loads, with
 * models of memory and of the store queue, and checks load data,
 * violations and the commit write port
 */

`timescale 1ns/1ps
`include "ldx_consts.svh"

module ldxPathTb;

	import ldxPkg::*;

	localparam int halfPeriod = 50;
	localparam int memWords = 1 << (`LDX_SIZE_ADDR - `LDX_BYTE_OFFSET);
	localparam logic [2:0] opLoad = 3'd0;
	localparam logic [2:0] opStore = 3'd1;
	localparam logic [2:0] opDisp = 3'd2;
	localparam logic [2:0] opCommit = 3'd3;
	localparam logic [2:0] opLdCommit = 3'd4;
	localparam logic [3:0] fromMem = 4'hf;

	// One table row; src names the forwarding store slot
	typedef struct packed {
		logic [2:0]                    op;
		lsqIdx_t                       idx;
		logic [`LDX_SIZE_ADDR-1:0]     addr;
		ldstSize_t                     size;
		logic                          sign;
		logic [3:0]                    src;
		logic                          vio;
	} stepRow_t;

	logic                          clk = 1'b0;
	logic                          reset;
	memReq_t                       stReq;
	memReq_t                       ldReq;
	dispPkt_t                      disp;
	stqState_t                     stq;
	logic                          commitSt;
	logic                          commitLd;
	lsqIdx_t                       commitLdIdx;
	logic [`LDX_SIZE_DATA-1:0]     ldData;
	logic [`LDX_SIZE_ADDR-1:0]     ldAddr;
	logic [`LDX_SIZE_ADDR-1:0]     stAddr;
	logic [`LDX_SIZE_DATA-1:0]     stData;
	logic [`LDX_BYTES-1:0]         stEn;
	logic [`LDX_SIZE_DATA-1:0]     loadData;
	logic                          loadDataValid;
	ldxVio_t                       vio;

	stepRow_t                      rows [$];
	logic [`LDX_SIZE_DATA-1:0]     memModel [memWords];
	logic [`LDX_SIZE_ADDR-1:0]     sqAddr [`LDX_SIZE_LSQ];
	ldstSize_t                     sqSize [`LDX_SIZE_LSQ];
	logic [`LDX_SIZE_DATA-1:0]     sqData [`LDX_SIZE_LSQ];
	lsqIdx_t                       head;
	lsqIdx_t                       tail;
	logic [`LDX_LSQ_LOG:0]         count;
	logic [31:0]                   lfsrState = 32'hf0b6eeab;
	int                            errorCount = 0;
	int                            checkCount = 0;
	int                            cycleCount = 0;
	int                            cycleLimit = 20;

	ldxPath i_dut (
		.clk              (clk),
		.reset            (reset),
		.stReq_i          (stReq),
		.ldReq_i          (ldReq),
		.disp_i           (disp),
		.stq_i            (stq),
		.commitSt_i       (commitSt),
		.commitLd_i       (commitLd),
		.commitLdIdx_i    (commitLdIdx),
		.ldData_i         (ldData),
		.ldAddr_o         (ldAddr),
		.stAddr_o         (stAddr),
		.stData_o         (stData),
		.stEn_o           (stEn),
		.loadData_o       (loadData),
		.loadDataValid_o  (loadDataValid),
		.vio_o            (vio)
	);

	// Single-cycle memory read port
	assign ldData = memModel[ldAddr[`LDX_SIZE_ADDR-1:`LDX_BYTE_OFFSET]];

	always #halfPeriod clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount > cycleLimit)
		begin
			$display("Timeout: the test sequence did not finish within %0d cycles", cycleLimit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per data bit
	task automatic randomWord(output logic [31:0] w);
		w = '0;
		for (int b = 0; b < 32; b++)
		begin
			w = {w[30:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState);
		end
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("ERR time=%0t %s got %h expected %h", $time, name, actual, expected);
		end
	endtask

	// Memory word shifted down by the offset, or the store's low bytes
	function automatic logic [31:0] expectLoad(input stepRow_t r);
		logic [31:0] raw;
		raw = (r.src == fromMem) ? (memModel[r.addr[15:2]] >> (8 * r.addr[1:0])) :
			sqData[r.src[2:0]];
		if (r.size == `LDX_SIZE_BYTE)
			return (r.sign && raw[7]) ? {24'hffffff, raw[7:0]} : {24'h0, raw[7:0]};
		if (r.size == `LDX_SIZE_HALF)
			return (r.sign && raw[15]) ? {16'hffff, raw[15:0]} : {16'h0, raw[15:0]};
		return raw;
	endfunction

	task automatic driveIdle();
		stReq = '0;
		ldReq = '0;
		disp = '0;
		commitSt = 1'b0;
		commitLd = 1'b0;
		commitLdIdx = '0;
		stq.head = head;
		stq.tail = tail;
		stq.count = count;
	endtask

	task automatic applyRow(input stepRow_t r);
		logic [31:0] storeWord;
		logic [3:0] expEn;
		logic [31:0] expData;
		driveIdle();
		case (r.op)
			opLoad:
			begin
				ldReq.valid = 1'b1;
				ldReq.lsqId = r.idx;
				ldReq.addr = r.addr;
				ldReq.size = r.size;
				ldReq.ldSign = r.sign;
			end
			opStore:
			begin
				randomWord(storeWord);
				sqAddr[tail] = r.addr;
				sqSize[tail] = r.size;
				sqData[tail] = storeWord;
				stReq.valid = 1'b1;
				stReq.lsqId = tail;
				stReq.addr = r.addr;
				stReq.size = r.size;
				stReq.data = storeWord;
			end
			opDisp:
			begin
				disp.valid = 1'b1;
				disp.ldqId = r.idx;
				disp.lastSt = tail - 1'b1;
			end
			opCommit:
				commitSt = 1'b1;
			default:
			begin
				commitLd = 1'b1;
				commitLdIdx = r.idx;
			end
		endcase
		#(halfPeriod / 2);
		checkValue("loadDataValid_o", loadDataValid, r.op == opLoad);
		checkValue("vio_o.valid", vio.valid, (r.op == opLoad) && r.vio);
		if (r.op == opLoad)
		begin
			checkValue("loadData_o", loadData, expectLoad(r));
			checkValue("ldAddr_o", ldAddr, {r.addr[15:2], 2'b00});
		end
		if ((r.op == opLoad) && r.vio)
			checkValue("vio_o.lsqId", vio.lsqId, r.idx);
		if (r.op == opCommit)
		begin
			expEn = (sqSize[head] == `LDX_SIZE_BYTE) ? 4'b0001 :
				(sqSize[head] == `LDX_SIZE_HALF) ? 4'b0011 : 4'b1111;
			expEn = expEn << sqAddr[head][1:0];
			expData = sqData[head] << (8 * sqAddr[head][1:0]);
			checkValue("stEn_o", stEn, expEn);
			checkValue("stData_o", stData, expData);
			checkValue("stAddr_o", stAddr, {sqAddr[head][15:2], 2'b00});
			for (int b = 0; b < `LDX_BYTES; b++)
			begin
				if (expEn[b])
					memModel[sqAddr[head][15:2]][8 * b +: 8] = expData[8 * b +: 8];
			end
			head++;
			count--;
		end
		else
			checkValue("stEn_o", stEn, 4'b0000);
		if (r.op == opStore)
		begin
			tail++;
			count++;
		end
	endtask

	task automatic addRow(input logic [2:0] op, input lsqIdx_t idx, input logic [15:0] addr,
		input ldstSize_t size, input logic sign, input logic [3:0] src, input logic vioExp);
		rows.push_back({op, idx, addr, size, sign, src, vioExp});
	endtask

	task automatic buildTable();
		// Memory loads in every size, signed and unsigned
		addRow(opLoad, 3'd0, 16'h0100, `LDX_SIZE_WORD, 1'b0, fromMem, 1'b0);
		addRow(opLoad, 3'd1, 16'h0105, `LDX_SIZE_BYTE, 1'b1, fromMem, 1'b0);
		addRow(opLoad, 3'd1, 16'h0104, `LDX_SIZE_HALF, 1'b1, fromMem, 1'b0);
		addRow(opLoad, 3'd2, 16'h0103, `LDX_SIZE_BYTE, 1'b0, fromMem, 1'b0);
		addRow(opLoad, 3'd2, 16'h0102, `LDX_SIZE_HALF, 1'b0, fromMem, 1'b0);
		addRow(opLoad, 3'd2, 16'h0106, `LDX_SIZE_HALF, 1'b1, fromMem, 1'b0);
		// One older store, forwarding and a partial overlap
		addRow(opStore, 3'd0, 16'h0200, `LDX_SIZE_WORD, 1'b0, fromMem, 1'b0);
		addRow(opDisp, 3'd3, 16'h0000, `LDX_SIZE_BYTE, 1'b0, fromMem, 1'b0);
		addRow(opLoad, 3'd3, 16'h0200, `LDX_SIZE_WORD, 1'b0, 4'd0, 1'b0);
		addRow(opLoad, 3'd3, 16'h0202, `LDX_SIZE_HALF, 1'b1, fromMem, 1'b1);
		addRow(opLoad, 3'd3, 16'h0200, `LDX_SIZE_BYTE, 1'b0, 4'd0, 1'b0);
		// Younger store to the same word decides
		addRow(opStore, 3'd0, 16'h0200, `LDX_SIZE_HALF, 1'b0, fromMem, 1'b0);
		addRow(opDisp, 3'd4, 16'h0000, `LDX_SIZE_BYTE, 1'b0, fromMem, 1'b0);
		addRow(opLoad, 3'd4, 16'h0200, `LDX_SIZE_BYTE, 1'b1, 4'd1, 1'b0);
		addRow(opLoad, 3'd4, 16'h0200, `LDX_SIZE_WORD, 1'b0, fromMem, 1'b1);
		addRow(opLoad, 3'd3, 16'h0200, `LDX_SIZE_WORD, 1'b0, 4'd0, 1'b0);
		addRow(opStore, 3'd0, 16'h0301, `LDX_SIZE_BYTE, 1'b0, fromMem, 1'b0);
		addRow(opDisp, 3'd5, 16'h0000, `LDX_SIZE_BYTE, 1'b0, fromMem, 1'b0);
		addRow(opLoad, 3'd5, 16'h0300, `LDX_SIZE_BYTE, 1'b0, fromMem, 1'b1);
		addRow(opLoad, 3'd5, 16'h0301, `LDX_SIZE_BYTE, 1'b1, 4'd2, 1'b0);
		// Commits, then loads whose last store has left
		addRow(opCommit, 3'd0, 16'h0000, `LDX_SIZE_BYTE, 1'b0, fromMem, 1'b0);
		addRow(opLoad, 3'd3, 16'h0200, `LDX_SIZE_WORD, 1'b0, fromMem, 1'b0);
		addRow(opLoad, 3'd4, 16'h0200, `LDX_SIZE_HALF, 1'b0, 4'd1, 1'b0);
		addRow(opCommit, 3'd0, 16'h0000, `LDX_SIZE_BYTE, 1'b0, fromMem, 1'b0);
		addRow(opLoad, 3'd4, 16'h0200, `LDX_SIZE_WORD, 1'b0, fromMem, 1'b0);
		addRow(opCommit, 3'd0, 16'h0000, `LDX_SIZE_BYTE, 1'b0, fromMem, 1'b0);
		addRow(opLoad, 3'd5, 16'h0300, `LDX_SIZE_WORD, 1'b0, fromMem, 1'b0);
		// Dispatch into an empty queue, then a load commit
		addRow(opDisp, 3'd6, 16'h0000, `LDX_SIZE_BYTE, 1'b0, fromMem, 1'b0);
		addRow(opStore, 3'd0, 16'h0400, `LDX_SIZE_WORD, 1'b0, fromMem, 1'b0);
		addRow(opLoad, 3'd6, 16'h0400, `LDX_SIZE_WORD, 1'b0, fromMem, 1'b0);
		addRow(opLoad, 3'd6, 16'h0402, `LDX_SIZE_HALF, 1'b1, fromMem, 1'b0);
		addRow(opDisp, 3'd7, 16'h0000, `LDX_SIZE_BYTE, 1'b0, fromMem, 1'b0);
		addRow(opLoad, 3'd7, 16'h0400, `LDX_SIZE_WORD, 1'b0, 4'd3, 1'b0);
		addRow(opLdCommit, 3'd7, 16'h0000, `LDX_SIZE_BYTE, 1'b0, fromMem, 1'b0);
		addRow(opLoad, 3'd7, 16'h0400, `LDX_SIZE_WORD, 1'b0, fromMem, 1'b0);
	endtask

	initial
	begin
		for (int i = 0; i < memWords; i++)
		begin
			memModel[i] = {i[13:0], 2'b01, ~i[13:0], 2'b10};
		end
		head = '0;
		tail = '0;
		count = '0;
		buildTable();
		cycleLimit = 4 * rows.size() + 20;
		reset = 1'b1;
		driveIdle();
		repeat (2) @(negedge clk);
		reset = 1'b0;
		#(halfPeriod / 2);
		checkValue("loadDataValid_o", loadDataValid, 1'b0);
		checkValue("vio_o.valid", vio.valid, 1'b0);
		checkValue("stEn_o", stEn, 4'b0000);
		foreach (rows[n])
		begin
			@(negedge clk);
			applyRow(rows[n]);
		end
		$display("Run finished: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+rtl
rtl/ldxPkg.sv
rtl/storeQueue.sv
rtl/loadQueue.sv
rtl/storeForward.sv
rtl/loadFormat.sv
rtl/ldxPath.sv
sim/ldxPathTb.sv
